// File: hdl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

////////////////////
// predictor sizing
////////////////////

// global history length, also the width of the pht index
`define HISTORY_BITS 8

// log2 of the btb entry count
`define BTB_INDEX_BITS 5

////////////////////
// memory and pc
////////////////////

// number of 64-bit lines, two instructions per line
`define IMEM_LINES 256

// first fetch address out of reset
`define RESET_PC 64'h0

`endif

// File: hdl/branch_pkg.sv
package branch_pkg;

  // resolution code reported by the back end, one per slot
  typedef enum logic [1:0] {
    RESULT_NONE      = 2'b00, // slot held no branch
    RESULT_NOT_TAKEN = 2'b01,
    RESULT_TAKEN     = 2'b10
  } branch_result_e;

  // true when the back end redirects fetch
  function automatic logic result_taken(branch_result_e result);
    return (result == RESULT_TAKEN);
  endfunction

  // true for any resolved branch, taken or not
  function automatic logic result_valid(branch_result_e result);
    return (result == RESULT_TAKEN) || (result == RESULT_NOT_TAKEN);
  endfunction

endpackage

// File: hdl/predict_pkg.sv
package predict_pkg;

  // 2-bit saturating counter states, ordered so that +1 means more taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } counter_e;

  // one step toward the outcome, pinned at both ends
  function automatic counter_e counter_step(counter_e state, logic taken);
    counter_e next_state;
    next_state = state;
    if (taken && (state != STRONG_T))
      next_state = counter_e'(state + 2'd1);
    else if (!taken && (state != STRONG_NT))
      next_state = counter_e'(state - 2'd1);
    return next_state;
  endfunction

  // upper half of the counter range predicts taken
  function automatic logic counter_taken(counter_e state);
    return (state == WEAK_T) || (state == STRONG_T);
  endfunction

endpackage

// File: hdl/branch_target_buffer.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module branch_target_buffer
  import branch_pkg::*;
(
  input  logic           clock,
  input  logic           reset,

  input  branch_result_e inst1_result_in,
  input  branch_result_e inst2_result_in,
  input  logic [63:0]    inst1_write_npc_in,  // pc+4 of the resolved branch
  input  logic [63:0]    inst2_write_npc_in,
  input  logic [63:0]    inst1_write_dest_in, // actual target
  input  logic [63:0]    inst2_write_dest_in,

  input  logic [63:0]    inst1_npc_in,        // lookup keys, pc+4 of each slot
  input  logic [63:0]    inst2_npc_in,
  output logic [63:0]    inst1_ppc_out,
  output logic [63:0]    inst2_ppc_out,
  output logic           inst1_hit,
  output logic           inst2_hit
);

  localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
  localparam int TAG_BITS = 64 - `BTB_INDEX_BITS; // upper npc bits plus the two low bits

  ////////////////////
  // entry storage
  ////////////////////

  logic                  valid [ENTRIES];
  logic [TAG_BITS-1:0]   tag   [ENTRIES];
  logic [63:0]           dest  [ENTRIES];

  // index is the word address right above the byte offset
  function automatic logic [`BTB_INDEX_BITS-1:0] btb_index(logic [63:0] npc);
    return npc[`BTB_INDEX_BITS+1:2];
  endfunction

  function automatic logic [TAG_BITS-1:0] btb_tag(logic [63:0] npc);
    return {npc[63:`BTB_INDEX_BITS+2], npc[1:0]};
  endfunction

  // slot 2 written last so it wins a shared entry
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < ENTRIES; i++)
        valid[i] <= 1'b0;
    end
    else
    begin
      if (result_taken(inst1_result_in))
      begin
        valid[btb_index(inst1_write_npc_in)] <= 1'b1;
        tag[btb_index(inst1_write_npc_in)]   <= btb_tag(inst1_write_npc_in);
        dest[btb_index(inst1_write_npc_in)]  <= inst1_write_dest_in;
      end
      if (result_taken(inst2_result_in))
      begin
        valid[btb_index(inst2_write_npc_in)] <= 1'b1;
        tag[btb_index(inst2_write_npc_in)]   <= btb_tag(inst2_write_npc_in);
        dest[btb_index(inst2_write_npc_in)]  <= inst2_write_dest_in;
      end
    end
  end

  ////////////////////
  // two read ports
  ////////////////////

  assign inst1_hit = valid[btb_index(inst1_npc_in)] &&
                     (tag[btb_index(inst1_npc_in)] == btb_tag(inst1_npc_in));
  assign inst2_hit = valid[btb_index(inst2_npc_in)] &&
                     (tag[btb_index(inst2_npc_in)] == btb_tag(inst2_npc_in));

  assign inst1_ppc_out = dest[btb_index(inst1_npc_in)]; // only meaningful on a hit
  assign inst2_ppc_out = dest[btb_index(inst2_npc_in)];

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module branch_predictor
  import branch_pkg::*;
  import predict_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,

  input  logic [63:0]               inst1_pc_in,        // slot pc+4
  input  logic [63:0]               inst2_pc_in,

  input  branch_result_e            inst1_result_in,
  input  branch_result_e            inst2_result_in,
  input  logic [`HISTORY_BITS-1:0]  inst1_pht_index_in, // index the branch was fetched with
  input  logic [`HISTORY_BITS-1:0]  inst2_pht_index_in,

  output logic                      inst1_prediction_out,
  output logic                      inst2_prediction_out,
  output logic [`HISTORY_BITS-1:0]  inst1_pht_index_out,
  output logic [`HISTORY_BITS-1:0]  inst2_pht_index_out,
  output logic [`HISTORY_BITS-1:0]  ghr
);

  localparam int PHT_ENTRIES = 1 << `HISTORY_BITS;

  counter_e                  pht [PHT_ENTRIES];
  logic [`HISTORY_BITS-1:0]  ghr_next;

  ////////////////////
  // lookup
  ////////////////////

  // gshare, word address bits folded with the history
  assign inst1_pht_index_out = inst1_pc_in[`HISTORY_BITS+1:2] ^ ghr;
  assign inst2_pht_index_out = inst2_pc_in[`HISTORY_BITS+1:2] ^ ghr;

  assign inst1_prediction_out = counter_taken(pht[inst1_pht_index_out]);
  assign inst2_prediction_out = counter_taken(pht[inst2_pht_index_out]);

  ////////////////////
  // update
  ////////////////////

  // history shifts slot 1 first, then slot 2
  always_comb
  begin
    ghr_next = ghr;
    if (result_valid(inst1_result_in))
      ghr_next = {ghr_next[`HISTORY_BITS-2:0], result_taken(inst1_result_in)};
    if (result_valid(inst2_result_in))
      ghr_next = {ghr_next[`HISTORY_BITS-2:0], result_taken(inst2_result_in)};
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      ghr <= '0;
      for (int i = 0; i < PHT_ENTRIES; i++)
        pht[i] <= WEAK_NT; // weakly not taken start
    end
    else
    begin
      ghr <= ghr_next;
      if (result_valid(inst1_result_in))
        pht[inst1_pht_index_in] <= counter_step(pht[inst1_pht_index_in],
                                                result_taken(inst1_result_in));
      // second assignment wins on a shared counter
      if (result_valid(inst2_result_in))
        pht[inst2_pht_index_in] <= counter_step(pht[inst2_pht_index_in],
                                                result_taken(inst2_result_in));
    end
  end

endmodule

// File: hdl/if_stage.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module if_stage
  import branch_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,

  // resolutions from the back end
  input  branch_result_e            inst1_result_in,
  input  branch_result_e            inst2_result_in,
  input  logic [63:0]               inst1_write_npc_in,
  input  logic [63:0]               inst2_write_npc_in,
  input  logic [63:0]               inst1_write_cpc_in,
  input  logic [63:0]               inst2_write_cpc_in,
  input  logic [`HISTORY_BITS-1:0]  inst1_pht_index_in,
  input  logic [`HISTORY_BITS-1:0]  inst2_pht_index_in,

  // instruction memory side
  input  logic [63:0]               imem_data,
  input  logic                      imem_valid,
  output logic [63:0]               imem_addr,

  // slot 1
  output logic [63:0]               if_npc_out_1,
  output logic [31:0]               if_ir_out_1,
  output logic                      if_valid_inst_out_1,
  output logic [63:0]               if_ppc_out_1,
  output logic [`HISTORY_BITS-1:0]  inst1_pht_index_out,

  // slot 2
  output logic [63:0]               if_npc_out_2,
  output logic [31:0]               if_ir_out_2,
  output logic                      if_valid_inst_out_2,
  output logic [63:0]               if_ppc_out_2,
  output logic [`HISTORY_BITS-1:0]  inst2_pht_index_out
);

  logic [63:0] pc_reg;      // pc being fetched this cycle
  logic [63:0] next_pc;
  logic        fetch_ok;    // line is usable this cycle
  logic        inst1_pred;  // gshare says taken
  logic        inst2_pred;
  logic        inst1_hit;   // btb holds this npc
  logic        inst2_hit;
  logic [63:0] inst1_btb_target;
  logic [63:0] inst2_btb_target;

  ////////////////////
  // pc and next pc
  ////////////////////

  assign imem_addr = {pc_reg[63:3], 3'b000}; // whole line

  assign if_npc_out_1 = pc_reg + 64'd4;
  assign if_npc_out_2 = pc_reg[2] ? if_npc_out_1 : pc_reg + 64'd8; // second word skips ahead 4

  assign fetch_ok = !stall && imem_valid;

  // taken resolutions beat stall and memory busy, slot 1 first
  always_comb
  begin
    if (result_taken(inst1_result_in))
      next_pc = inst1_write_cpc_in;
    else if (result_taken(inst2_result_in))
      next_pc = inst2_write_cpc_in;
    else if (!fetch_ok)
      next_pc = pc_reg;        // hold
    else
      next_pc = if_npc_out_2;  // sequential
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= `RESET_PC;
    else
      pc_reg <= next_pc;
  end

  ////////////////////
  // slot outputs
  ////////////////////

  assign if_ir_out_1 = imem_data[63:32]; // upper word
  assign if_ir_out_2 = imem_data[31:0];

  assign if_valid_inst_out_1 = fetch_ok && !pc_reg[2]; // first word skipped on odd pc
  assign if_valid_inst_out_2 = fetch_ok;

  // prediction only reported, never steers the pc
  assign if_ppc_out_1 = (inst1_pred && inst1_hit) ? inst1_btb_target : if_npc_out_1;
  assign if_ppc_out_2 = (inst2_pred && inst2_hit) ? inst2_btb_target : if_npc_out_2;

  branch_target_buffer btb (
    .clock               (clock),
    .reset               (reset),
    .inst1_result_in     (inst1_result_in),
    .inst2_result_in     (inst2_result_in),
    .inst1_write_npc_in  (inst1_write_npc_in),
    .inst2_write_npc_in  (inst2_write_npc_in),
    .inst1_write_dest_in (inst1_write_cpc_in),
    .inst2_write_dest_in (inst2_write_cpc_in),
    .inst1_npc_in        (if_npc_out_1),
    .inst2_npc_in        (if_npc_out_2),
    .inst1_ppc_out       (inst1_btb_target),
    .inst2_ppc_out       (inst2_btb_target),
    .inst1_hit           (inst1_hit),
    .inst2_hit           (inst2_hit)
  );

  branch_predictor bp (
    .clock                (clock),
    .reset                (reset),
    .inst1_pc_in          (if_npc_out_1),
    .inst2_pc_in          (if_npc_out_2),
    .inst1_result_in      (inst1_result_in),
    .inst2_result_in      (inst2_result_in),
    .inst1_pht_index_in   (inst1_pht_index_in),
    .inst2_pht_index_in   (inst2_pht_index_in),
    .inst1_prediction_out (inst1_pred),
    .inst2_prediction_out (inst2_pred),
    .inst1_pht_index_out  (inst1_pht_index_out),
    .inst2_pht_index_out  (inst2_pht_index_out),
    .ghr                  ()  // history is visible inside bp only
  );

endmodule

// File: hdl/inst_mem.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module inst_mem (
  input  logic        clock,
  input  logic        reset,
  input  logic        load_en,     // write strobe, blocks fetch
  input  logic [63:0] load_addr,
  input  logic [63:0] load_data,
  input  logic [63:0] fetch_addr,
  output logic [63:0] fetch_data,
  output logic        mem_valid
);

  localparam int LINE_BITS = $clog2(`IMEM_LINES);

  logic [63:0] lines [`IMEM_LINES];
  logic        ready_q;           // clear through reset, set afterwards

  // byte address to line, upper pc bits dropped
  always_ff @(posedge clock)
  begin
    if (load_en)
      lines[load_addr[LINE_BITS+2:3]] <= load_data;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      ready_q <= 1'b0;
    else
      ready_q <= 1'b1;
  end

  assign fetch_data = lines[fetch_addr[LINE_BITS+2:3]]; // async read
  assign mem_valid  = ready_q && !load_en;

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_unit
  import branch_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,

  input  branch_result_e            inst1_result_in,
  input  branch_result_e            inst2_result_in,
  input  logic [63:0]               inst1_write_npc_in,
  input  logic [63:0]               inst2_write_npc_in,
  input  logic [63:0]               inst1_write_cpc_in,
  input  logic [63:0]               inst2_write_cpc_in,
  input  logic [`HISTORY_BITS-1:0]  inst1_pht_index_in,
  input  logic [`HISTORY_BITS-1:0]  inst2_pht_index_in,

  input  logic                      load_en,
  input  logic [63:0]               load_addr,
  input  logic [63:0]               load_data,

  output logic [63:0]               if_npc_out_1,
  output logic [31:0]               if_ir_out_1,
  output logic                      if_valid_inst_out_1,
  output logic [63:0]               if_ppc_out_1,
  output logic [`HISTORY_BITS-1:0]  inst1_pht_index_out,

  output logic [63:0]               if_npc_out_2,
  output logic [31:0]               if_ir_out_2,
  output logic                      if_valid_inst_out_2,
  output logic [63:0]               if_ppc_out_2,
  output logic [`HISTORY_BITS-1:0]  inst2_pht_index_out
);

  logic [63:0] imem_addr;   // line address from the stage
  logic [63:0] imem_data;
  logic        imem_valid;

  if_stage if_stage_i (
    .clock               (clock),
    .reset               (reset),
    .stall               (stall),
    .inst1_result_in     (inst1_result_in),
    .inst2_result_in     (inst2_result_in),
    .inst1_write_npc_in  (inst1_write_npc_in),
    .inst2_write_npc_in  (inst2_write_npc_in),
    .inst1_write_cpc_in  (inst1_write_cpc_in),
    .inst2_write_cpc_in  (inst2_write_cpc_in),
    .inst1_pht_index_in  (inst1_pht_index_in),
    .inst2_pht_index_in  (inst2_pht_index_in),
    .imem_data           (imem_data),
    .imem_valid          (imem_valid),
    .imem_addr           (imem_addr),
    .if_npc_out_1        (if_npc_out_1),
    .if_ir_out_1         (if_ir_out_1),
    .if_valid_inst_out_1 (if_valid_inst_out_1),
    .if_ppc_out_1        (if_ppc_out_1),
    .inst1_pht_index_out (inst1_pht_index_out),
    .if_npc_out_2        (if_npc_out_2),
    .if_ir_out_2         (if_ir_out_2),
    .if_valid_inst_out_2 (if_valid_inst_out_2),
    .if_ppc_out_2        (if_ppc_out_2),
    .inst2_pht_index_out (inst2_pht_index_out)
  );

  inst_mem inst_mem_i (
    .clock      (clock),
    .reset      (reset),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (imem_addr),
    .fetch_data (imem_data),
    .mem_valid  (imem_valid)
  );

endmodule

// File: testbench/fetch_ref_model.svh
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

////////////////////
// reference state
////////////////////

localparam int REF_LINE_BITS = $clog2(`IMEM_LINES);
localparam int REF_BTB_SIZE  = 1 << `BTB_INDEX_BITS;
localparam int REF_PHT_SIZE  = 1 << `HISTORY_BITS;

logic [63:0]              ref_pc;
logic                     ref_ready;                    // memory has left reset
logic [63:0]              ref_mem       [`IMEM_LINES];
logic                     ref_btb_valid [REF_BTB_SIZE];
logic [63:0]              ref_btb_npc   [REF_BTB_SIZE]; // whole npc kept, acts as the tag
logic [63:0]              ref_btb_dest  [REF_BTB_SIZE];
counter_e                 ref_pht       [REF_PHT_SIZE];
logic [`HISTORY_BITS-1:0] ref_ghr;

// npc of the second slot, one word on from an odd pc
function automatic logic [63:0] seq_npc(logic [63:0] pc);
  return pc[2] ? pc + 64'd4 : pc + 64'd8;
endfunction

function automatic logic [`HISTORY_BITS-1:0] pht_slot(logic [63:0] npc);
  return npc[`HISTORY_BITS+1:2] ^ ref_ghr; // gshare
endfunction

// btb target only when the counter leans taken and the same npc was stored
function automatic logic [63:0] predicted_pc(logic [63:0] npc);
  logic [`BTB_INDEX_BITS-1:0] b;
  b = npc[`BTB_INDEX_BITS+1:2];
  if ((ref_pht[pht_slot(npc)] >= WEAK_T) && ref_btb_valid[b] && (ref_btb_npc[b] == npc))
    return ref_btb_dest[b];
  else
    return npc;
endfunction

task automatic reset_model();
  ref_pc    = `RESET_PC;
  ref_ready = 1'b0;
  ref_ghr   = '0;
  for (int i = 0; i < REF_BTB_SIZE; i++)
    ref_btb_valid[i] = 1'b0;
  for (int i = 0; i < REF_PHT_SIZE; i++)
    ref_pht[i] = WEAK_NT;
endtask

// state after the coming clock edge, from the inputs now on the pins
task automatic advance_model();
  counter_e                   c1;
  counter_e                   c2;
  logic [`BTB_INDEX_BITS-1:0] b;
  logic                       t1;
  logic                       t2;
  t1 = (inst1_result_in == RESULT_TAKEN);
  t2 = (inst2_result_in == RESULT_TAKEN);
  if (load_en)
    ref_mem[load_addr[REF_LINE_BITS+2:3]] = load_data; // loads ignore reset
  if (reset)
    reset_model();
  else
  begin
    if (t1)
      ref_pc = inst1_write_cpc_in;  // slot 1 redirect first
    else if (t2)
      ref_pc = inst2_write_cpc_in;
    else if (ref_ready && !load_en && !stall)
      ref_pc = seq_npc(ref_pc);
    ref_ready = 1'b1;
    // both counters step from old values, slot 2 lands last
    c1 = counter_step(ref_pht[inst1_pht_index_in], t1);
    c2 = counter_step(ref_pht[inst2_pht_index_in], t2);
    if (inst1_result_in != RESULT_NONE)
    begin
      ref_pht[inst1_pht_index_in] = c1;
      ref_ghr = {ref_ghr[`HISTORY_BITS-2:0], t1};
    end
    if (inst2_result_in != RESULT_NONE)
    begin
      ref_pht[inst2_pht_index_in] = c2;
      ref_ghr = {ref_ghr[`HISTORY_BITS-2:0], t2};
    end
    if (t1)
    begin
      b = inst1_write_npc_in[`BTB_INDEX_BITS+1:2];
      ref_btb_valid[b] = 1'b1;
      ref_btb_npc[b]   = inst1_write_npc_in;
      ref_btb_dest[b]  = inst1_write_cpc_in;
    end
    if (t2)
    begin
      b = inst2_write_npc_in[`BTB_INDEX_BITS+1:2];
      ref_btb_valid[b] = 1'b1;
      ref_btb_npc[b]   = inst2_write_npc_in;
      ref_btb_dest[b]  = inst2_write_cpc_in;
    end
  end
endtask

`endif

// File: testbench/fetch_tb.sv
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_tb
  import branch_pkg::*;
  import predict_pkg::*;
();

  localparam int CLOCK_PERIOD   = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int LOAD_CYCLES    = `IMEM_LINES;  // one preload line per clock
  localparam int STIM_CYCLES    = 4000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + LOAD_CYCLES + STIM_CYCLES + 100;

  logic                     clock;
  logic                     reset;
  logic                     stall;
  branch_result_e           inst1_result_in;
  branch_result_e           inst2_result_in;
  logic [63:0]              inst1_write_npc_in;
  logic [63:0]              inst2_write_npc_in;
  logic [63:0]              inst1_write_cpc_in;
  logic [63:0]              inst2_write_cpc_in;
  logic [`HISTORY_BITS-1:0] inst1_pht_index_in;
  logic [`HISTORY_BITS-1:0] inst2_pht_index_in;
  logic                     load_en;
  logic [63:0]              load_addr;
  logic [63:0]              load_data;
  logic [63:0]              if_npc_out_1;
  logic [31:0]              if_ir_out_1;
  logic                     if_valid_inst_out_1;
  logic [63:0]              if_ppc_out_1;
  logic [`HISTORY_BITS-1:0] inst1_pht_index_out;
  logic [63:0]              if_npc_out_2;
  logic [31:0]              if_ir_out_2;
  logic                     if_valid_inst_out_2;
  logic [63:0]              if_ppc_out_2;
  logic [`HISTORY_BITS-1:0] inst2_pht_index_out;

  int unsigned              checks;
  int unsigned              errors;
  logic [31:0]              lcg_state;
  logic [63:0]              seen_npc   [8];  // recently fetched npcs replayed as branch pcs
  logic [`HISTORY_BITS-1:0] seen_index [8];
  logic [2:0]               seen_ptr;

  `include "fetch_ref_model.svh"

  fetch_unit fetch_unit_i (.*);

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic branch_result_e pick_result(logic [2:0] r);
    if (r == 3'd7)
      return RESULT_TAKEN;     // one in eight
    else if (r >= 3'd5)
      return RESULT_NOT_TAKEN;
    else
      return RESULT_NONE;
  endfunction

  task automatic clear_inputs();
    stall = 1'b0;
    inst1_result_in = RESULT_NONE;
    inst2_result_in = RESULT_NONE;
    inst1_write_npc_in = '0;
    inst2_write_npc_in = '0;
    inst1_write_cpc_in = '0;
    inst2_write_cpc_in = '0;
    inst1_pht_index_in = '0;
    inst2_pht_index_in = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r = next_random();
    clear_inputs();
    stall = (r[3:0] < 4'd4);  // about a quarter of cycles
    load_en = (r[7:4] == 4'd0);
    load_addr = {next_random(), next_random()}; // upper bits must not matter
    load_data = {next_random(), next_random()};
    inst1_result_in = pick_result(r[10:8]);
    inst2_result_in = pick_result(r[13:11]);
    if (inst1_result_in != RESULT_NONE)
    begin
      inst1_write_npc_in = seen_npc[r[16:14]];
      inst1_pht_index_in = seen_index[r[16:14]];
      inst1_write_cpc_in = 64'({next_random() % 32'(2 * `IMEM_LINES), 2'b00});
    end
    if (inst2_result_in != RESULT_NONE)
    begin
      inst2_write_npc_in = seen_npc[r[19:17]];
      inst2_pht_index_in = seen_index[r[19:17]];
      inst2_write_cpc_in = 64'({next_random() % 32'(2 * `IMEM_LINES), 2'b00});
      if (r[21:20] == 2'd0)
      begin
        inst2_write_npc_in = inst1_write_npc_in; // same btb entry and counter
        inst2_pht_index_in = inst1_pht_index_in;
      end
    end
  endtask

  // keep a fetched slot around so a later resolution can name it
  task automatic record_branch_pc(logic [63:0] npc, logic [`HISTORY_BITS-1:0] index);
    seen_npc[seen_ptr] = npc;
    seen_index[seen_ptr] = index;
    seen_ptr = seen_ptr + 3'd1;
  endtask

  ////////////////////
  // checking
  ////////////////////

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_outputs();
    logic        ok;
    logic [63:0] line;
    ok = !reset && ref_ready && !load_en && !stall;
    line = ref_mem[ref_pc[REF_LINE_BITS+2:3]];
    check_value("valid_1", 64'(ok && !ref_pc[2]), 64'(if_valid_inst_out_1));
    check_value("valid_2", 64'(ok), 64'(if_valid_inst_out_2));
    check_value("npc_1", ref_pc + 64'd4, if_npc_out_1);
    check_value("npc_2", seq_npc(ref_pc), if_npc_out_2);
    check_value("ppc_1", predicted_pc(ref_pc + 64'd4), if_ppc_out_1);
    check_value("ppc_2", predicted_pc(seq_npc(ref_pc)), if_ppc_out_2);
    check_value("pht_index_1", 64'(pht_slot(ref_pc + 64'd4)), 64'(inst1_pht_index_out));
    check_value("pht_index_2", 64'(pht_slot(seq_npc(ref_pc))), 64'(inst2_pht_index_out));
    if (ok)
    begin
      check_value("ir_1", 64'(line[63:32]), 64'(if_ir_out_1));
      check_value("ir_2", 64'(line[31:0]), 64'(if_ir_out_2));
      if (!ref_pc[2])
        record_branch_pc(ref_pc + 64'd4, pht_slot(ref_pc + 64'd4)); // slot 1 npcs are odd words
      record_branch_pc(seq_npc(ref_pc), pht_slot(seq_npc(ref_pc)));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    clock = 1'b0;
    reset = 1'b1;
    checks = 0;
    errors = 0;
    lcg_state = 32'd11370;
    seen_ptr = '0;
    for (int i = 0; i < 8; i++)
    begin
      seen_npc[i] = 64'(4 * (i + 1));
      seen_index[i] = '0;
    end
    clear_inputs();
    reset_model();
    for (int c = 0; c < RESET_CYCLES; c++)
    begin
      @(posedge clock);
      #1 reset = (c < RESET_CYCLES - 1); // low from the last drive on
      #5 check_outputs();
      advance_model();
    end
    for (int l = 0; l < LOAD_CYCLES; l++)
    begin
      @(posedge clock);
      #1 load_en = 1'b1;
      load_addr = 64'(l * 8);
      load_data = {next_random(), next_random()};
      #5 check_outputs();
      advance_model();
    end
    for (int s = 0; s < STIM_CYCLES; s++)
    begin
      @(posedge clock);
      #1 drive_random();
      #5 check_outputs();
      advance_model();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog sized from the three phases plus margin
  initial
  begin
    #(TIMEOUT_CYCLES * CLOCK_PERIOD);
    $display("watchdog expired before the stimulus loop finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: tb.f
+incdir+hdl
+incdir+testbench
hdl/branch_pkg.sv
hdl/predict_pkg.sv
hdl/branch_target_buffer.sv
hdl/branch_predictor.sv
hdl/if_stage.sv
hdl/inst_mem.sv
hdl/fetch_unit.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "fetch_tb passed"
else
  echo "fetch_tb failed"
  exit 1
fi
